//--- design/uartPkg.sv
`default_nettype none

package uartPkg;

	////////////////////////////////
	// frame format
	////////////////////////////////
	localparam int dataBits = 8;		// payload bits per frame
	localparam int sbTick = 16;		// ticks in the stop bit
	localparam int osTicks = 16;		// ticks per start/data bit

	////////////////////////////////
	// widths
	////////////////////////////////
	typedef logic [dataBits-1:0] uartData_t;	// one byte through fifos and shifters
	typedef logic [15:0] divisor_t;		// baud divisor
	typedef logic [11:0] apbAddr_t;
	typedef logic [31:0] apbData_t;

	// register map, byte offsets
	localparam apbAddr_t regDataOff = 12'h000;	// tx push / rx pop
	localparam apbAddr_t regStatOff = 12'h004;	// flags + sticky overrun
	localparam apbAddr_t regDivOff = 12'h008;	// baud divisor

	// shared by both serial machines
	typedef enum logic [1:0] {
		idle = 2'b00,
		start = 2'b01,
		data = 2'b10,
		stop = 2'b11
	} serState_t;

endpackage

`default_nettype wire

//--- design/fifoIf.sv
`default_nettype none

// access to one show-ahead fifo
interface fifoIf;

	logic push;			// write strobe
	uartPkg::uartData_t wrData;
	logic full;
	logic pop;			// read strobe, head advances
	uartPkg::uartData_t rdData;	// always the current head
	logic empty;

	// producer side, sees both flags for status
	modport writer (output push, wrData, input full, empty);

	// consumer side
	modport reader (output pop, input rdData, empty, full);

	// the storage itself
	modport store (input push, wrData, pop, output full, rdData, empty);

endinterface

`default_nettype wire

//--- design/uartRegs.sv
`default_nettype none

module uartRegs #(
	parameter uartPkg::divisor_t divisorReset = 16'd1
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input uartPkg::apbAddr_t paddr,
	input uartPkg::apbData_t pwdata,
	output uartPkg::apbData_t prdata,
	output logic pready,
	output logic pslverr,
	fifoIf.writer txQ,		// regs -> transmitter
	fifoIf.reader rxQ,		// receiver -> regs
	input logic overrun,
	output uartPkg::divisor_t divisor
);

	////////////////////////////////
	// address decode
	////////////////////////////////
	logic access;		// access phase of a transfer
	logic wrEn;
	logic rdEn;
	logic hitData;
	logic hitStat;
	logic hitDiv;
	logic mapped;

	uartPkg::divisor_t divReg;
	logic overrunSticky;
	logic [4:0] status;

	assign access = psel & penable;
	assign wrEn = access & pwrite;
	assign rdEn = access & ~pwrite;

	assign hitData = (paddr == uartPkg::regDataOff);
	assign hitStat = (paddr == uartPkg::regStatOff);
	assign hitDiv = (paddr == uartPkg::regDivOff);
	assign mapped = hitData | hitStat | hitDiv;

	assign pready = 1'b1;		// never stalls
	assign pslverr = access & ~mapped;	// unmapped offset

	////////////////////////////////
	// fifo strobes
	////////////////////////////////
	// fifo itself drops push when full
	assign txQ.push = wrEn & hitData;
	assign txQ.wrData = pwdata[uartPkg::dataBits-1:0];

	// read returns head, pop advances it after this cycle
	assign rxQ.pop = rdEn & hitData;

	////////////////////////////////
	// divisor and overrun
	////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divReg <= divisorReset;
			overrunSticky <= 1'b0;
		end
		else
		begin
			if (wrEn && hitDiv)
				divReg <= pwdata[15:0];

			// a new overrun beats a same-cycle clear
			if (overrun)
				overrunSticky <= 1'b1;
			else if (wrEn && hitStat && pwdata[4])
				overrunSticky <= 1'b0;	// write 1 to clear
		end
	end

	assign divisor = divReg;

	// bit 0 txFull .. bit 4 overrun
	assign status = {overrunSticky, rxQ.empty, rxQ.full, txQ.empty, txQ.full};

	////////////////////////////////
	// read mux
	////////////////////////////////
	always_comb
	begin
		prdata = '0;
		if (rdEn)
		begin
			if (hitData)
				prdata = {24'd0, rxQ.rdData};	// head of rx fifo
			else if (hitStat)
				prdata = {27'd0, status};
			else if (hitDiv)
				prdata = {16'd0, divReg};
		end
	end

endmodule

`default_nettype wire

//--- design/baudTickGen.sv
`default_nettype none

// oversampling tick, one pulse every divisor+1 clocks
module baudTickGen (
	input logic clk,
	input logic reset,
	input uartPkg::divisor_t divisor,
	output logic sTick
);

	uartPkg::divisor_t cnt;	// counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (cnt == '0)
			cnt <= divisor;		// new divisor picked up here
		else
			cnt <= cnt - 1'b1;
	end

	// pulse on the zero cycle
	assign sTick = (cnt == '0);

endmodule

`default_nettype wire

//--- design/uartFifo.sv
`default_nettype none

// show-ahead circular buffer, head always on rdData
module uartFifo #(
	parameter int fifoDepthLog2 = 4
) (
	input logic clk,
	input logic reset,
	fifoIf.store q
);

	localparam int depth = 2 ** fifoDepthLog2;

	////////////////////////////////
	// storage and pointers
	////////////////////////////////
	uartPkg::uartData_t mem [depth];

	// extra msb tells full from empty
	logic [fifoDepthLog2:0] wrPtr;
	logic [fifoDepthLog2:0] rdPtr;

	logic doPush;
	logic doPop;

	assign q.empty = (wrPtr == rdPtr);
	assign q.full = (wrPtr[fifoDepthLog2] != rdPtr[fifoDepthLog2]) &&
		(wrPtr[fifoDepthLog2-1:0] == rdPtr[fifoDepthLog2-1:0]);

	// drop push when full, pop when empty
	assign doPush = q.push & ~q.full;
	assign doPop = q.pop & ~q.empty;

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[fifoDepthLog2-1:0]] <= q.wrData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;	// push and pop may coincide
		end
	end

	assign q.rdData = mem[rdPtr[fifoDepthLog2-1:0]];	// head

endmodule

`default_nettype wire

//--- design/uartTrans.sv
`default_nettype none

module uartTrans (
	input logic clk,
	input logic reset,
	input logic sTick,
	fifoIf.reader txQ,
	output logic tx
);

	localparam int cntW = $clog2(uartPkg::osTicks);	// tick counter width
	localparam int bitW = $clog2(uartPkg::dataBits);	// bit counter width

	uartPkg::serState_t stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;		// ticks within a bit
	logic [bitW-1:0] nReg, nNext;		// bits sent
	uartPkg::uartData_t bReg, bNext;	// shift register, lsb goes out
	logic txReg, txNext;		// registered line
	logic txDoneTick;			// pops the fifo

	////////////////////////////////
	// state registers
	////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			bReg <= '0;
			txReg <= 1'b1;		// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			bReg <= bNext;
			txReg <= txNext;
		end
	end

	////////////////////////////////
	// next state
	////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				if (!txQ.empty)		// start request
				begin
					txDoneTick = 1'b1;	// pop and latch head together
					bNext = txQ.rdData;
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				txNext = 1'b0;		// start bit
				if (sTick)
				begin
					if (sReg == cntW'(uartPkg::osTicks - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				txNext = bReg[0];	// lsb first
				if (sTick)
				begin
					if (sReg == cntW'(uartPkg::osTicks - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == bitW'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == cntW'(uartPkg::sbTick - 1))
						stateNext = uartPkg::idle;	// next byte may start at once
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::idle;
		endcase
	end

	assign txQ.pop = txDoneTick;
	assign tx = txReg;

endmodule

`default_nettype wire

//--- design/uartRecv.sv
`default_nettype none

module uartRecv (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	fifoIf.writer rxQ,
	output logic overrun
);

	localparam int cntW = $clog2(uartPkg::osTicks);
	localparam int bitW = $clog2(uartPkg::dataBits);

	logic rxMeta, rxSync;		// two-flop synchronizer
	logic rxPrev;			// for edge detect
	logic fallEdge;

	uartPkg::serState_t stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;
	logic [bitW-1:0] nReg, nNext;
	uartPkg::uartData_t bReg, bNext;	// shifts in from the top
	logic byteDone;			// good stop bit sampled

	////////////////////////////////
	// input sync
	////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign fallEdge = rxPrev & ~rxSync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			bReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			bReg <= bNext;
		end
	end

	////////////////////////////////
	// next state
	////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		byteDone = 1'b0;

		case (stateReg)
			uartPkg::idle:
			begin
				if (fallEdge)
				begin
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				if (sTick)
				begin
					// middle of start bit
					if (sReg == cntW'(uartPkg::osTicks / 2 - 1))
					begin
						sNext = '0;
						nNext = '0;
						if (!rxSync)
							stateNext = uartPkg::data;
						else
							stateNext = uartPkg::idle;	// glitch, not a start
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				if (sTick)
				begin
					if (sReg == cntW'(uartPkg::osTicks - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartPkg::dataBits-1:1]};	// lsb first
						if (nReg == bitW'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stop:
			begin
				if (sTick)
				begin
					if (sReg == cntW'(uartPkg::sbTick - 1))
					begin
						byteDone = rxSync;	// low stop bit drops the frame
						stateNext = uartPkg::idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::idle;
		endcase
	end

	// full fifo loses the byte and flags it
	assign rxQ.push = byteDone & ~rxQ.full;
	assign rxQ.wrData = bReg;
	assign overrun = byteDone & rxQ.full;

endmodule

`default_nettype wire

//--- design/uartPeriph.sv
`default_nettype none

module uartPeriph #(
	parameter int fifoDepthLog2 = 4,
	parameter uartPkg::divisor_t divisorReset = 16'd1
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input uartPkg::apbAddr_t paddr,
	input uartPkg::apbData_t pwdata,
	output uartPkg::apbData_t prdata,
	output logic pready,
	output logic pslverr,
	input logic rx,
	output logic tx
);

	////////////////////////////////
	// internal nets
	////////////////////////////////
	uartPkg::divisor_t divisor;
	logic sTick;		// 16x oversampling
	logic overrun;

	fifoIf txIf ();		// regs -> transmitter
	fifoIf rxIf ();		// receiver -> regs

	uartRegs #(
		.divisorReset(divisorReset)
	) regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.txQ(txIf.writer),
		.rxQ(rxIf.reader),
		.overrun(overrun),
		.divisor(divisor)
	);

	baudTickGen tickGen (.clk(clk), .reset(reset), .divisor(divisor), .sTick(sTick));

	// same fifo, one per direction
	uartFifo #(.fifoDepthLog2(fifoDepthLog2)) txFifo (.clk(clk), .reset(reset), .q(txIf.store));
	uartFifo #(.fifoDepthLog2(fifoDepthLog2)) rxFifo (.clk(clk), .reset(reset), .q(rxIf.store));

	uartTrans trans (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txQ(txIf.reader),
		.tx(tx)
	);

	uartRecv recv (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxQ(rxIf.writer),
		.overrun(overrun)
	);

endmodule

`default_nettype wire

//--- bench/uartPeriphTb.sv
`default_nettype none

module uartPeriphTb;

	localparam int clkPeriod = 100;
	localparam int txDiv = 1;			// divisor used for all frames
	localparam int numBytes = 8;		// loopback test
	localparam int fillBytes = 17;		// 16 in fifo + 1 on the line
	localparam int dropBytes = 3;		// writes that hit a full fifo
	localparam int bitCycles = uartPkg::osTicks * (txDiv + 1);
	// one start, eight data and one stop bit plus slack
	localparam int frameCycles = bitCycles * (uartPkg::dataBits + 2) + 4;
	localparam int watchdogCycles = (numBytes + fillBytes + dropBytes) * 4 * frameCycles + 5000;
	localparam int maxPolls = 2 * frameCycles / 3;	// status reads per wait

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	uartPkg::apbAddr_t paddr;
	uartPkg::apbData_t pwdata;
	uartPkg::apbData_t prdata;
	logic pready;
	logic pslverr;
	logic txLine;		// tx looped back to rx

	int errors;
	logic [31:0] rngState;
	logic [7:0] expQ[$];	// bytes accepted by the tx fifo
	logic [7:0] seenQ[$];	// bytes decoded on the line

	uartPeriph dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rx(txLine),
		.tx(txLine)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkVal(input string msg, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s, expected %0h, got %0h", $time, msg, exp, act);
		end
	endtask

	// setup phase, access phase, then idle
	task automatic writeReg(input uartPkg::apbAddr_t addr, input uartPkg::apbData_t data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;		// written on the next rising edge
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic readReg(input uartPkg::apbAddr_t addr, output uartPkg::apbData_t data,
		output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#(clkPeriod / 4);	// prdata settled before the pop edge
		data = prdata;
		err = pslverr;
		checkVal("pready in access phase", 1, pready);	// no wait states
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// poll status until one bit has a value or the poll limit runs out
	task automatic waitStatus(input int bitIdx, input logic val, output logic [4:0] st);
		uartPkg::apbData_t d;
		logic e;
		int n;
		n = 0;
		readReg(uartPkg::regStatOff, d, e);
		while (d[bitIdx] !== val && n < maxPolls)
		begin
			readReg(uartPkg::regStatOff, d, e);
			n++;
		end
		st = d[4:0];
	endtask

	// block until count frames are decoded
	task automatic waitFrames(input int count);
		while (seenQ.size() < count)
			@(posedge clk);
	endtask

	//////////////////////////////
	// tx frame monitor
	//////////////////////////////
	initial
	begin : frameMonitor
		logic [7:0] b;
		forever
		begin
			@(negedge txLine);		// start edge
			#(bitCycles * clkPeriod / 2 + clkPeriod / 2);	// centre of the start bit
			checkVal("start bit", 0, txLine);
			for (int i = 0; i < uartPkg::dataBits; i++)
			begin
				#(bitCycles * clkPeriod);
				b[i] = txLine;		// lsb first
			end
			#(bitCycles * clkPeriod);
			checkVal("stop bit", 1, txLine);
			seenQ.push_back(b);
		end
	end

	initial
	begin : watchdog
		#(watchdogCycles * clkPeriod);
		$display("Timeout: the run did not complete within %0d clock cycles", watchdogCycles);
		$display("Errors found");
		$finish;
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial
	begin : mainSeq
		uartPkg::apbData_t d;
		uartPkg::apbData_t v;
		logic e;
		logic [4:0] st;

		errors = 0;
		rngState = 32'hc8125016;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// only txEmpty and rxEmpty set after reset
		readReg(uartPkg::regStatOff, d, e);
		checkVal("status after reset", 32'h0000000a, d);
		readReg(uartPkg::regDivOff, d, e);
		checkVal("divisor after reset", 1, d);

		// small random divisors so the old reload dies out quickly
		repeat (8)
		begin
			rngState = xorshift(rngState);
			v = {24'd0, rngState[7:0]};
			writeReg(uartPkg::regDivOff, v);
			readReg(uartPkg::regDivOff, d, e);
			checkVal("divisor readback", v, d);
			checkVal("pslverr on mapped read", 0, e);
		end
		readReg(12'h00c, d, e);
		checkVal("pslverr on unmapped read", 1, e);
		readReg(12'h100, d, e);
		checkVal("pslverr on unmapped read", 1, e);
		writeReg(uartPkg::regDivOff, txDiv);
		repeat (300) @(posedge clk);	// counter reloads with txDiv

		// random frames checked on the line and read back through rx
		for (int i = 0; i < numBytes; i++)
		begin
			rngState = xorshift(rngState);
			writeReg(uartPkg::regDataOff, {24'd0, rngState[7:0]});
			expQ.push_back(rngState[7:0]);
		end
		waitFrames(numBytes);
		for (int i = 0; i < numBytes; i++)
			checkVal("tx frame data", expQ[i], seenQ[i]);
		for (int i = 0; i < numBytes; i++)
		begin
			waitStatus(3, 1'b0, st);	// rx byte there
			checkVal("rx not empty", 0, st[3]);
			readReg(uartPkg::regDataOff, d, e);
			checkVal("loopback data", expQ[i], d);
		end
		readReg(uartPkg::regStatOff, d, e);
		checkVal("rx empty after readback", 1, d[3]);

		expQ.delete();
		seenQ.delete();

		// first byte goes to the shifter and the next 16 fill the fifo
		rngState = xorshift(rngState);
		writeReg(uartPkg::regDataOff, {24'd0, rngState[7:0]});
		expQ.push_back(rngState[7:0]);
		waitStatus(1, 1'b1, st);
		checkVal("tx fifo drained by shifter", 1, st[1]);
		for (int i = 1; i < fillBytes; i++)
		begin
			rngState = xorshift(rngState);
			writeReg(uartPkg::regDataOff, {24'd0, rngState[7:0]});
			expQ.push_back(rngState[7:0]);
		end
		readReg(uartPkg::regStatOff, d, e);
		checkVal("txFull", 1, d[0]);
		for (int i = 0; i < dropBytes; i++)
		begin
			rngState = xorshift(rngState);
			writeReg(uartPkg::regDataOff, {24'd0, rngState[7:0]});	// dropped
		end
		waitFrames(fillBytes);
		for (int i = 0; i < fillBytes; i++)
			checkVal("tx frame after fill", expQ[i], seenQ[i]);

		// 17th received byte overruns the rx fifo
		waitStatus(4, 1'b1, st);
		checkVal("overrun set", 1, st[4]);
		checkVal("rxFull", 1, st[2]);
		writeReg(uartPkg::regStatOff, 32'h10);	// write 1 clears
		readReg(uartPkg::regStatOff, d, e);
		checkVal("overrun cleared", 0, d[4]);
		for (int i = 0; i < 16; i++)
		begin
			readReg(uartPkg::regDataOff, d, e);
			checkVal("rx data after overrun", expQ[i], d);
		end
		readReg(uartPkg::regStatOff, d, e);
		checkVal("rx empty at end", 1, d[3]);

		repeat (10) @(posedge clk);
		$display("error count: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartPeriph.f
design/uartPkg.sv
design/fifoIf.sv
design/uartRegs.sv
design/baudTickGen.sv
design/uartFifo.sv
design/uartTrans.sv
design/uartRecv.sv
design/uartPeriph.sv
bench/uartPeriphTb.sv

//--- Bender.yml
package:
  name: uartPeriph

dependencies: {}

sources:
  # package and interface first, then the RTL blocks, then the top level
  - design/uartPkg.sv
  - design/fifoIf.sv
  - design/uartRegs.sv
  - design/baudTickGen.sv
  - design/uartFifo.sv
  - design/uartTrans.sv
  - design/uartRecv.sv
  - design/uartPeriph.sv

  - target: simulation
    files:
      - bench/uartPeriphTb.sv
